/* sim.f */
+incdir+include
hw/cu_pkg.sv
hw/ctrl_if.sv
hw/instr_decoder.sv
hw/stack_sequencer.sv
hw/control_unit.sv
verification/control_unit_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module control_unit_tb -o control_unit_tb
	./obj_dir/control_unit_tb | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* include/cu_tb_table.svh */
`ifndef CU_TB_TABLE_SVH
`define CU_TB_TABLE_SVH

// expected controls per instruction word, register fields left at zero
typedef struct packed {
    logic [15:0] instr;
    logic [3:0]  alu_op;
    logic        reg_write;
    logic [1:0]  wb_sel;
    logic        mem_read;
    logic        mem_write;
    logic        mem_push;
    logic        mem_pop;
    logic [1:0]  carry_sel;
    logic [2:0]  jump_sel;
    logic        alu_src_imm;
    logic        clear_instruction;
    logic        out_enable;
    logic        in_select;
} cu_tb_row_t;

localparam int CU_TB_ROWS = 25;

// instr, alu, rw, wb, rd, wr, push, pop, carry, jump, imm, clr, out, in
localparam cu_tb_row_t CU_TB_TABLE [CU_TB_ROWS] = '{
    // not inc dec add sub and or
    '{16'h0000, 4'd0, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h0800, 4'd1, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h1000, 4'd2, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h1800, 4'd3, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h2000, 4'd4, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h2800, 4'd5, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h3000, 4'd6, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    // nop setc clrc out in push pop
    '{16'h4000, 4'd15, '0, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h4800, 4'd15, '0, 2'd1, '0, '0, '0, '0, 2'd1, 3'd0, '0, '0, '0, '0},
    '{16'h5000, 4'd15, '0, 2'd1, '0, '0, '0, '0, 2'd2, 3'd0, '0, '0, '0, '0},
    '{16'h5800, 4'd15, '0, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '1, '0},
    '{16'h6000, 4'd15, '1, 2'd3, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '1},
    '{16'h6800, 4'd15, '0, 2'd1, '0, '1, '1, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h7000, 4'd15, '1, 2'd2, '1, '0, '0, '1, 2'd0, 3'd0, '0, '0, '0, '0},
    // mov ldm ldd std shl shr
    '{16'h8000, 4'd15, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h8800, 4'd15, '1, 2'd0, '0, '0, '0, '0, 2'd0, 3'd0, '0, '1, '0, '0},
    '{16'h9000, 4'd15, '1, 2'd2, '1, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'h9800, 4'd15, '0, 2'd1, '0, '1, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0},
    '{16'hA000, 4'd7, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '1, '0, '0, '0},
    '{16'hA800, 4'd8, '1, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '1, '0, '0, '0},
    // jz jn jc jmp, then reti as a no-op
    '{16'hC000, 4'd15, '0, 2'd1, '0, '0, '0, '0, 2'd0, 3'd4, '0, '0, '0, '0},
    '{16'hC800, 4'd15, '0, 2'd1, '0, '0, '0, '0, 2'd0, 3'd5, '0, '0, '0, '0},
    '{16'hD000, 4'd15, '0, 2'd1, '0, '0, '0, '0, 2'd0, 3'd6, '0, '0, '0, '0},
    '{16'hD800, 4'd15, '0, 2'd1, '0, '0, '0, '0, 2'd0, 3'd7, '0, '0, '0, '0},
    '{16'hF000, 4'd15, '0, 2'd1, '0, '0, '0, '0, 2'd0, 3'd0, '0, '0, '0, '0}
};

`endif

/* verification/control_unit_tb.sv */
module control_unit_tb;

    `include "cu_tb_table.svh"

    logic                        clk;
    logic                        reset;
    logic [cu_pkg::INSTR_W-1:0]  instruction;
    cu_pkg::alu_op_t             alu_op;
    logic                        alu_src_imm;
    logic                        flag_write;
    cu_pkg::carry_sel_t          carry_sel;
    cu_pkg::jump_sel_t           jump_sel;
    logic                        mem_read;
    logic                        mem_write;
    logic                        mem_push;
    logic                        mem_pop;
    cu_pkg::mem_addr_sel_t       mem_addr_sel;
    cu_pkg::mem_src_sel_t        mem_src_sel;
    logic                        reg_write;
    cu_pkg::wb_sel_t             wb_sel;
    logic                        out_enable;
    logic                        in_select;
    logic                        clear_instruction;
    logic [cu_pkg::REG_ID_W-1:0] r_src;
    logic [cu_pkg::REG_ID_W-1:0] r_dst;
    logic                        stall_fetch;
    logic                        pc_choose_memory;

    int          errors;
    int          checks;
    logic [31:0] seed = 32'd93;
    logic [15:0] word;
    logic [15:0] add_word;

    control_unit dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // random bits in the rdst and rsrc fields only
    function automatic logic [15:0] random_fields();
        logic [31:0] r;
        r = lcg_next();
        return {5'd0, r[18:13], 5'd0};
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR t=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
        end
    endtask

    // register ids, flag write and memory selects follow the word's opcode
    task automatic expected_fields(input logic [15:0] w, output logic [3:0] dst,
                                   output logic [3:0] src, output logic flag,
                                   output logic [1:0] addr, output logic [1:0] msrc);
        logic [2:0] op;
        logic [3:0] fd;
        logic [3:0] fs;
        op   = w[13:11];
        fd   = {1'b0, w[cu_pkg::RDST_HI:cu_pkg::RDST_LO]};
        fs   = {1'b0, w[cu_pkg::RSRC_HI:cu_pkg::RSRC_LO]};
        dst  = 4'd0;
        src  = 4'd0;
        flag = 1'b0;
        addr = cu_pkg::ADDR_RDST;
        msrc = cu_pkg::MSRC_NONE;
        case (w[15:14])
            2'd0:
            begin
                dst  = fd;
                flag = 1'b1;
                if (op >= 3'd3)
                    src = fs;
            end
            2'd1:
            begin
                flag = (op == 3'd1 || op == 3'd2);
                // out names its register in the dst field
                if (op == 3'd3)
                    src = fd;
                if (op >= 3'd4 && op <= 3'd6)
                    dst = fd;
                if (op == 3'd5 || op == 3'd6)
                begin
                    addr = cu_pkg::ADDR_SP;
                    msrc = cu_pkg::MSRC_REG;
                end
            end
            2'd2:
            begin
                flag = (op == 3'd4 || op == 3'd5);
                if (op <= 3'd5)
                    dst = fd;
                if (op == 3'd0 || op == 3'd2 || op == 3'd3)
                    src = fs;
                if (op == 3'd2)
                    addr = cu_pkg::ADDR_RSRC;
                if (op == 3'd3)
                    msrc = cu_pkg::MSRC_REG;
            end
            default:
                if (op <= 3'd3)
                    dst = fd;
        endcase
    endtask

    task automatic apply_word(input logic [15:0] w);
        @(posedge clk);
        #2;
        instruction = w;
        #16;
    endtask

    task automatic check_row(input cu_tb_row_t row, input logic [15:0] w);
        logic [3:0] dst;
        logic [3:0] src;
        logic       flag;
        logic [1:0] addr;
        logic [1:0] msrc;
        expected_fields(w, dst, src, flag, addr, msrc);
        check_value("alu_op", 16'(row.alu_op), 16'(alu_op));
        check_value("reg_write", 16'(row.reg_write), 16'(reg_write));
        check_value("wb_sel", 16'(row.wb_sel), 16'(wb_sel));
        check_value("mem_read", 16'(row.mem_read), 16'(mem_read));
        check_value("mem_write", 16'(row.mem_write), 16'(mem_write));
        check_value("mem_push", 16'(row.mem_push), 16'(mem_push));
        check_value("mem_pop", 16'(row.mem_pop), 16'(mem_pop));
        check_value("carry_sel", 16'(row.carry_sel), 16'(carry_sel));
        check_value("jump_sel", 16'(row.jump_sel), 16'(jump_sel));
        check_value("alu_src_imm", 16'(row.alu_src_imm), 16'(alu_src_imm));
        check_value("clear_instruction", 16'(row.clear_instruction), 16'(clear_instruction));
        check_value("out_enable", 16'(row.out_enable), 16'(out_enable));
        check_value("in_select", 16'(row.in_select), 16'(in_select));
        check_value("r_dst", 16'(dst), 16'(r_dst));
        check_value("r_src", 16'(src), 16'(r_src));
        check_value("flag_write", 16'(flag), 16'(flag_write));
        check_value("mem_addr_sel", 16'(addr), 16'(mem_addr_sel));
        check_value("mem_src_sel", 16'(msrc), 16'(mem_src_sel));
        check_value("stall_fetch", 16'd0, 16'(stall_fetch));
        check_value("pc_choose_memory", 16'd0, 16'(pc_choose_memory));
    endtask

    // one cycle of a call or ret sequence where the alu stays idle
    task automatic check_stack(input logic push, input logic pop, input logic [1:0] msrc,
                               input logic [2:0] jump, input logic clr, input logic stall,
                               input logic pcmem, input logic [3:0] dst);
        logic [1:0] addr;
        addr = (push || pop) ? cu_pkg::ADDR_SP : cu_pkg::ADDR_RDST;
        check_value("alu_op", 16'(cu_pkg::ALU_NONE), 16'(alu_op));
        check_value("reg_write", 16'd0, 16'(reg_write));
        check_value("mem_push", 16'(push), 16'(mem_push));
        check_value("mem_write", 16'(push), 16'(mem_write));
        check_value("mem_pop", 16'(pop), 16'(mem_pop));
        check_value("mem_read", 16'(pop), 16'(mem_read));
        check_value("mem_addr_sel", 16'(addr), 16'(mem_addr_sel));
        check_value("mem_src_sel", 16'(msrc), 16'(mem_src_sel));
        check_value("jump_sel", 16'(jump), 16'(jump_sel));
        check_value("clear_instruction", 16'(clr), 16'(clear_instruction));
        check_value("stall_fetch", 16'(stall), 16'(stall_fetch));
        check_value("pc_choose_memory", 16'(pcmem), 16'(pc_choose_memory));
        check_value("r_dst", 16'(dst), 16'(r_dst));
        // nothing else may leak through from the word on the input
        check_value("r_src", 16'd0, 16'(r_src));
        check_value("flag_write", 16'd0, 16'(flag_write));
        check_value("alu_src_imm", 16'd0, 16'(alu_src_imm));
        check_value("carry_sel", 16'(cu_pkg::CARRY_KEEP), 16'(carry_sel));
        check_value("wb_sel", 16'(cu_pkg::WB_ALU), 16'(wb_sel));
        check_value("out_enable", 16'd0, 16'(out_enable));
        check_value("in_select", 16'd0, 16'(in_select));
    endtask

    initial
    begin
        reset       = 1'b0;
        instruction = '0;
        errors      = 0;
        checks      = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b1;

        for (int i = 0; i < CU_TB_ROWS; i++)
        begin
            word = CU_TB_TABLE[i].instr | random_fields();
            apply_word(word);
            check_row(CU_TB_TABLE[i], word);
        end

        // call with an add in the second cycle that must be ignored
        word     = 16'hE000 | random_fields();
        add_word = CU_TB_TABLE[3].instr | random_fields();
        apply_word(word);
        check_stack(1'b1, 1'b0, cu_pkg::MSRC_PC_HIGH, cu_pkg::JMP_NONE, 1'b0, 1'b1, 1'b0,
                    {1'b0, word[cu_pkg::RDST_HI:cu_pkg::RDST_LO]});
        apply_word(add_word);
        check_stack(1'b1, 1'b0, cu_pkg::MSRC_PC_LOW, cu_pkg::JMP_ALWAYS, 1'b0, 1'b0, 1'b0,
                    4'd0);
        apply_word(add_word);
        check_row(CU_TB_TABLE[3], add_word);

        // ret pops twice and then waits out the bubbles
        apply_word(16'hE800 | random_fields());
        check_stack(1'b0, 1'b1, cu_pkg::MSRC_NONE, cu_pkg::JMP_NONE, 1'b1, 1'b0, 1'b0,
                    cu_pkg::PC_HIGH_REG);
        apply_word(add_word);
        check_stack(1'b0, 1'b1, cu_pkg::MSRC_NONE, cu_pkg::JMP_NONE, 1'b1, 1'b0, 1'b1,
                    cu_pkg::PC_LOW_REG);
        repeat (cu_pkg::RET_WAIT_CYCLES)
        begin
            apply_word(add_word);
            check_stack(1'b0, 1'b0, cu_pkg::MSRC_NONE, cu_pkg::JMP_NONE, 1'b1, 1'b0, 1'b0,
                        4'd0);
        end
        apply_word(add_word);
        check_row(CU_TB_TABLE[3], add_word);

        // reset in the middle of the ret wait
        apply_word(16'hE800);
        apply_word(add_word);
        apply_word(add_word);
        @(posedge clk);
        #2;
        reset = 1'b0;
        #16;
        check_row(CU_TB_TABLE[3], add_word);
        @(posedge clk);
        #2;
        reset = 1'b1;
        apply_word(add_word);
        check_row(CU_TB_TABLE[3], add_word);

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        #((CU_TB_ROWS + 20) * 20 * 2);
        $display("watchdog expired before the test sequence finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* hw/control_unit.sv */
module control_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [cu_pkg::INSTR_W-1:0]  instruction,
    output cu_pkg::alu_op_t             alu_op,
    output logic                        alu_src_imm,
    output logic                        flag_write,
    output cu_pkg::carry_sel_t          carry_sel,
    output cu_pkg::jump_sel_t           jump_sel,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        mem_push,
    output logic                        mem_pop,
    output cu_pkg::mem_addr_sel_t       mem_addr_sel,
    output cu_pkg::mem_src_sel_t        mem_src_sel,
    output logic                        reg_write,
    output cu_pkg::wb_sel_t             wb_sel,
    output logic                        out_enable,
    output logic                        in_select,
    output logic                        clear_instruction,
    output logic [cu_pkg::REG_ID_W-1:0] r_src,
    output logic [cu_pkg::REG_ID_W-1:0] r_dst,
    output logic                        stall_fetch,
    output logic                        pc_choose_memory
);

    // decoded controls of the current word
    ctrl_if             decoded_bus ();
    cu_pkg::flow_kind_t flow;

    instr_decoder u_decoder (
        .instruction (instruction),
        .ctrl        (decoded_bus),
        .flow        (flow)
    );

    // all stage controls leave through the sequencer
    stack_sequencer u_sequencer (
        .decoded (decoded_bus),
        .*
    );

endmodule

/* hw/stack_sequencer.sv */
module stack_sequencer (
    input  logic                        clk,
    input  logic                        reset,
    ctrl_if.consumer                    decoded,
    input  cu_pkg::flow_kind_t          flow,
    output cu_pkg::alu_op_t             alu_op,
    output logic                        alu_src_imm,
    output logic                        flag_write,
    output cu_pkg::carry_sel_t          carry_sel,
    output cu_pkg::jump_sel_t           jump_sel,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        mem_push,
    output logic                        mem_pop,
    output cu_pkg::mem_addr_sel_t       mem_addr_sel,
    output cu_pkg::mem_src_sel_t        mem_src_sel,
    output logic                        reg_write,
    output cu_pkg::wb_sel_t             wb_sel,
    output logic                        out_enable,
    output logic                        in_select,
    output logic                        clear_instruction,
    output logic [cu_pkg::REG_ID_W-1:0] r_src,
    output logic [cu_pkg::REG_ID_W-1:0] r_dst,
    output logic                        stall_fetch,
    output logic                        pc_choose_memory
);

    cu_pkg::seq_state_t            state;
    logic [cu_pkg::WAIT_CNT_W-1:0] wait_cnt;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state    <= cu_pkg::SEQ_IDLE;
            wait_cnt <= '0;
        end
        else
        begin
            case (state)
                cu_pkg::SEQ_IDLE:
                begin
                    if (flow == cu_pkg::FLOW_CALL)
                        state <= cu_pkg::SEQ_CALL_LOW;
                    else if (flow == cu_pkg::FLOW_RET)
                        state <= cu_pkg::SEQ_RET_LOW;
                end
                cu_pkg::SEQ_RET_LOW:
                begin
                    state    <= cu_pkg::SEQ_RET_WAIT;
                    wait_cnt <= '0;
                end
                cu_pkg::SEQ_RET_WAIT:
                begin
                    if (wait_cnt == cu_pkg::WAIT_LAST)
                        state <= cu_pkg::SEQ_IDLE;
                    wait_cnt <= wait_cnt + 1'b1;
                end
                default:
                    state <= cu_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_comb
    begin
        stall_fetch      = 1'b0;
        pc_choose_memory = 1'b0;
        if (state == cu_pkg::SEQ_IDLE)
        begin
            alu_op            = decoded.alu_op;
            alu_src_imm       = decoded.alu_src_imm;
            flag_write        = decoded.flag_write;
            carry_sel         = decoded.carry_sel;
            jump_sel          = decoded.jump_sel;
            mem_read          = decoded.mem_read;
            mem_write         = decoded.mem_write;
            mem_push          = decoded.mem_push;
            mem_pop           = decoded.mem_pop;
            mem_addr_sel      = decoded.mem_addr_sel;
            mem_src_sel       = decoded.mem_src_sel;
            reg_write         = decoded.reg_write;
            wb_sel            = decoded.wb_sel;
            out_enable        = decoded.out_enable;
            in_select         = decoded.in_select;
            clear_instruction = decoded.clear_instruction;
            r_src             = decoded.r_src;
            r_dst             = decoded.r_dst;
            // hold fetch while the two pc halves go out
            stall_fetch       = (flow == cu_pkg::FLOW_CALL);
        end
        else
        begin
            // instruction input is ignored mid-sequence
            alu_op            = cu_pkg::ALU_NONE;
            alu_src_imm       = 1'b0;
            flag_write        = 1'b0;
            carry_sel         = cu_pkg::CARRY_KEEP;
            jump_sel          = cu_pkg::JMP_NONE;
            mem_read          = 1'b0;
            mem_write         = 1'b0;
            mem_push          = 1'b0;
            mem_pop           = 1'b0;
            mem_addr_sel      = cu_pkg::ADDR_RDST;
            mem_src_sel       = cu_pkg::MSRC_NONE;
            reg_write         = 1'b0;
            wb_sel            = cu_pkg::WB_ALU;
            out_enable        = 1'b0;
            in_select         = 1'b0;
            clear_instruction = 1'b1;
            r_src             = '0;
            r_dst             = '0;
            case (state)
                cu_pkg::SEQ_CALL_LOW:
                begin
                    // lower half, then jump to the target in execute
                    clear_instruction = 1'b0;
                    mem_push          = 1'b1;
                    mem_write         = 1'b1;
                    mem_addr_sel      = cu_pkg::ADDR_SP;
                    mem_src_sel       = cu_pkg::MSRC_PC_LOW;
                    jump_sel          = cu_pkg::JMP_ALWAYS;
                end
                cu_pkg::SEQ_RET_LOW:
                begin
                    mem_pop          = 1'b1;
                    mem_read         = 1'b1;
                    mem_addr_sel     = cu_pkg::ADDR_SP;
                    r_dst            = cu_pkg::PC_LOW_REG;
                    pc_choose_memory = 1'b1;
                end
                default:
                    ;
            endcase
        end
    end

endmodule

/* hw/instr_decoder.sv */
module instr_decoder (
    input  logic [cu_pkg::INSTR_W-1:0] instruction,
    ctrl_if.producer                   ctrl,
    output cu_pkg::flow_kind_t         flow
);

    cu_pkg::instr_class_t        iclass;
    logic [2:0]                  opcode;
    logic [cu_pkg::REG_ID_W-1:0] dst_id;
    logic [cu_pkg::REG_ID_W-1:0] src_id;

    assign iclass = cu_pkg::instr_class_t'(instruction[cu_pkg::INSTR_W-1 -: 2]);
    assign opcode = instruction[cu_pkg::INSTR_W-3 -: 3];
    assign dst_id = {1'b0, instruction[cu_pkg::RDST_HI:cu_pkg::RDST_LO]};
    assign src_id = {1'b0, instruction[cu_pkg::RSRC_HI:cu_pkg::RSRC_LO]};

    always_comb
    begin
        // everything inactive unless the opcode says otherwise
        ctrl.alu_op            = cu_pkg::ALU_NONE;
        ctrl.alu_src_imm       = 1'b0;
        ctrl.flag_write        = 1'b0;
        ctrl.carry_sel         = cu_pkg::CARRY_KEEP;
        ctrl.jump_sel          = cu_pkg::JMP_NONE;
        ctrl.mem_read          = 1'b0;
        ctrl.mem_write         = 1'b0;
        ctrl.mem_push          = 1'b0;
        ctrl.mem_pop           = 1'b0;
        ctrl.mem_addr_sel      = cu_pkg::ADDR_RDST;
        ctrl.mem_src_sel       = cu_pkg::MSRC_NONE;
        ctrl.reg_write         = 1'b0;
        ctrl.wb_sel            = cu_pkg::WB_ALU;
        ctrl.out_enable        = 1'b0;
        ctrl.in_select         = 1'b0;
        ctrl.clear_instruction = 1'b0;
        ctrl.r_src             = '0;
        ctrl.r_dst             = '0;
        flow                   = cu_pkg::FLOW_NONE;

        case (iclass)
            cu_pkg::CLASS_ALU:
            begin
                // opcode maps straight onto the alu code, 7 is unused
                if (opcode != 3'd7)
                begin
                    ctrl.alu_op     = cu_pkg::alu_op_t'({1'b0, opcode});
                    ctrl.flag_write = 1'b1;
                    ctrl.reg_write  = 1'b1;
                    ctrl.r_dst      = dst_id;
                    // add and up take a second register
                    if (opcode >= 3'd3)
                        ctrl.r_src = src_id;
                end
            end

            cu_pkg::CLASS_ONE_OP:
            begin
                case (opcode)
                    3'd1, 3'd2:
                    begin
                        // setc / clrc
                        ctrl.carry_sel  = (opcode == 3'd1) ? cu_pkg::CARRY_SET : cu_pkg::CARRY_CLEAR;
                        ctrl.flag_write = 1'b1;
                    end
                    3'd3:
                    begin
                        // out reads the register named in the dst field
                        ctrl.out_enable = 1'b1;
                        ctrl.r_src      = dst_id;
                    end
                    3'd4:
                    begin
                        ctrl.in_select = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.wb_sel    = cu_pkg::WB_INPORT;
                        ctrl.r_dst     = dst_id;
                    end
                    3'd5, 3'd6:
                    begin
                        // push on 5, pop on 6
                        ctrl.mem_addr_sel = cu_pkg::ADDR_SP;
                        ctrl.mem_src_sel  = cu_pkg::MSRC_REG;
                        ctrl.r_dst        = dst_id;
                        ctrl.mem_push     = (opcode == 3'd5);
                        ctrl.mem_write    = (opcode == 3'd5);
                        ctrl.mem_pop      = (opcode == 3'd6);
                        ctrl.mem_read     = (opcode == 3'd6);
                        ctrl.reg_write    = (opcode == 3'd6);
                        if (opcode == 3'd6)
                            ctrl.wb_sel = cu_pkg::WB_MEM;
                    end
                    default:
                        ;
                endcase
            end

            cu_pkg::CLASS_TWO_OP:
            begin
                ctrl.r_dst = dst_id;
                case (opcode)
                    3'd0:
                    begin
                        // mov goes through the alu untouched
                        ctrl.reg_write = 1'b1;
                        ctrl.r_src     = src_id;
                    end
                    3'd1:
                    begin
                        // ldm, the immediate is the next word
                        ctrl.clear_instruction = 1'b1;
                        ctrl.reg_write         = 1'b1;
                        ctrl.wb_sel            = cu_pkg::WB_IMM;
                    end
                    3'd2:
                    begin
                        ctrl.mem_read     = 1'b1;
                        ctrl.mem_addr_sel = cu_pkg::ADDR_RSRC;
                        ctrl.reg_write    = 1'b1;
                        ctrl.wb_sel       = cu_pkg::WB_MEM;
                        ctrl.r_src        = src_id;
                    end
                    3'd3:
                    begin
                        // std stores rsrc at the address in rdst
                        ctrl.mem_write   = 1'b1;
                        ctrl.mem_src_sel = cu_pkg::MSRC_REG;
                        ctrl.r_src       = src_id;
                    end
                    3'd4, 3'd5:
                    begin
                        ctrl.alu_op      = (opcode == 3'd4) ? cu_pkg::ALU_SHL : cu_pkg::ALU_SHR;
                        ctrl.alu_src_imm = 1'b1;
                        ctrl.flag_write  = 1'b1;
                        ctrl.reg_write   = 1'b1;
                    end
                    default:
                        ctrl.r_dst = '0;
                endcase
            end

            cu_pkg::CLASS_BRANCH:
            begin
                case (opcode)
                    3'd0, 3'd1, 3'd2, 3'd3:
                    begin
                        ctrl.jump_sel = cu_pkg::jump_sel_t'({1'b1, opcode[1:0]});
                        ctrl.r_dst    = dst_id;
                    end
                    3'd4:
                    begin
                        // call, first cycle pushes the upper pc half
                        flow              = cu_pkg::FLOW_CALL;
                        ctrl.mem_push     = 1'b1;
                        ctrl.mem_write    = 1'b1;
                        ctrl.mem_addr_sel = cu_pkg::ADDR_SP;
                        ctrl.mem_src_sel  = cu_pkg::MSRC_PC_HIGH;
                        ctrl.r_dst        = dst_id;
                    end
                    3'd5:
                    begin
                        // ret, first pop lands in the upper pc half
                        flow                   = cu_pkg::FLOW_RET;
                        ctrl.mem_pop           = 1'b1;
                        ctrl.mem_read          = 1'b1;
                        ctrl.mem_addr_sel      = cu_pkg::ADDR_SP;
                        ctrl.clear_instruction = 1'b1;
                        ctrl.r_dst             = cu_pkg::PC_HIGH_REG;
                    end
                    default:
                        ;
                endcase
            end

            default:
                ;
        endcase
    end

endmodule

/* hw/ctrl_if.sv */
interface ctrl_if;

    // execute stage
    cu_pkg::alu_op_t       alu_op;
    logic                  alu_src_imm;
    logic                  flag_write;
    cu_pkg::carry_sel_t    carry_sel;
    cu_pkg::jump_sel_t     jump_sel;
    // memory stage
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_push;
    logic                  mem_pop;
    cu_pkg::mem_addr_sel_t mem_addr_sel;
    cu_pkg::mem_src_sel_t  mem_src_sel;
    // write back and fetch
    logic                  reg_write;
    cu_pkg::wb_sel_t       wb_sel;
    logic                  out_enable;
    logic                  in_select;
    logic                  clear_instruction;
    logic [cu_pkg::REG_ID_W-1:0] r_src;
    logic [cu_pkg::REG_ID_W-1:0] r_dst;

    modport producer (
        output alu_op, alu_src_imm, flag_write, carry_sel, jump_sel,
        output mem_read, mem_write, mem_push, mem_pop, mem_addr_sel, mem_src_sel,
        output reg_write, wb_sel, out_enable, in_select, clear_instruction, r_src, r_dst
    );

    modport consumer (
        input alu_op, alu_src_imm, flag_write, carry_sel, jump_sel,
        input mem_read, mem_write, mem_push, mem_pop, mem_addr_sel, mem_src_sel,
        input reg_write, wb_sel, out_enable, in_select, clear_instruction, r_src, r_dst
    );

endinterface

/* hw/cu_pkg.sv */
package cu_pkg;

    // instruction word layout
    localparam int INSTR_W  = 16;
    localparam int REG_ID_W = 4;
    localparam int RDST_HI  = 10;
    localparam int RDST_LO  = 8;
    localparam int RSRC_HI  = 7;
    localparam int RSRC_LO  = 5;

    // pc halves, written through the register file on a pop
    localparam logic [REG_ID_W-1:0] PC_HIGH_REG = 4'd8;
    localparam logic [REG_ID_W-1:0] PC_LOW_REG  = 4'd9;

    // bubbles after the second ret pop until the target is fetched
    localparam int RET_WAIT_CYCLES = 2;
    localparam int WAIT_CNT_W      = $clog2(RET_WAIT_CYCLES + 1);
    localparam logic [WAIT_CNT_W-1:0] WAIT_LAST = WAIT_CNT_W'(RET_WAIT_CYCLES - 1);

    typedef enum logic [1:0] {
        CLASS_ALU,
        CLASS_ONE_OP,
        CLASS_TWO_OP,
        CLASS_BRANCH
    } instr_class_t;

    typedef enum logic [3:0] {
        ALU_NOT  = 4'd0,
        ALU_INC  = 4'd1,
        ALU_DEC  = 4'd2,
        ALU_ADD  = 4'd3,
        ALU_SUB  = 4'd4,
        ALU_AND  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_SHL  = 4'd7,
        ALU_SHR  = 4'd8,
        ALU_NONE = 4'd15
    } alu_op_t;

    typedef enum logic [1:0] {CARRY_KEEP, CARRY_SET, CARRY_CLEAR} carry_sel_t;

    // msb set means a jump, low bits pick the condition
    typedef enum logic [2:0] {
        JMP_NONE   = 3'd0,
        JMP_ZERO   = 3'd4,
        JMP_NEG    = 3'd5,
        JMP_CARRY  = 3'd6,
        JMP_ALWAYS = 3'd7
    } jump_sel_t;

    typedef enum logic [1:0] {WB_IMM, WB_ALU, WB_MEM, WB_INPORT} wb_sel_t;

    typedef enum logic [1:0] {ADDR_RDST, ADDR_RSRC, ADDR_SP} mem_addr_sel_t;

    typedef enum logic [1:0] {MSRC_NONE, MSRC_PC_HIGH, MSRC_PC_LOW, MSRC_REG} mem_src_sel_t;

    typedef enum logic [1:0] {FLOW_NONE, FLOW_CALL, FLOW_RET} flow_kind_t;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_CALL_LOW, SEQ_RET_LOW, SEQ_RET_WAIT} seq_state_t;

endpackage
